// ==== verilog.f ====
+incdir+.
posit_pkg.sv
pd_if.sv
posit_add_flow.sv
posit_add_align.sv
posit_add_norm.sv
posit_adder.sv
posit_adder_chk.sv
tb_posit_adder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_posit_adder -o tb_posit_adder \
    && ./obj_dir/tb_posit_adder +verilator+error+limit+100 | tee /dev/stderr \
    | grep -q "TEST PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb_posit_adder.sv ====
`timescale 1ns/1ps
`include "posit_params.svh"

module tb_posit_adder;
    import posit_pkg::*;

    localparam int n_pairs    = 64;
    localparam int calm_pairs = 16;
    localparam int wait_limit = 200;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    logic out_valid;
    logic out_ready;
    pd_t  a_drv;
    pd_t  b_drv;
    pd_t  res;
    int   stall_pct;
    int   sent;
    int   results;

    posit_adder posit_adder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .a_sign     (a_drv.sign),
        .a_zero     (a_drv.zero),
        .a_nar      (a_drv.nar),
        .a_scale    (a_drv.scale),
        .a_frac     (a_drv.frac),
        .b_sign     (b_drv.sign),
        .b_zero     (b_drv.zero),
        .b_nar      (b_drv.nar),
        .b_scale    (b_drv.scale),
        .b_frac     (b_drv.frac),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_sign   (res.sign),
        .out_zero   (res.zero),
        .out_nar    (res.nar),
        .out_scale  (res.scale),
        .out_frac   (res.frac),
        .out_guard  (res.guard),
        .out_round  (res.round),
        .out_sticky (res.sticky)
    );

    bind posit_adder posit_adder_chk chk_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic fail_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    function automatic pd_t random_operand();
        pd_t x;
        x       = '0;
        x.sign  = 1'($urandom % 2);
        x.scale = scale_t'(int'($urandom % (2 * `MAX_SCALE + 1)) - `MAX_SCALE);
        x.frac  = frac_t'($urandom);
        return x;
    endfunction

    task automatic send_pair(input pd_t a, input pd_t b);
        int waited;
        a_drv    = a;
        b_drv    = b;
        in_valid = 1'b1;
        waited   = 0;
        // in_ready is registered and holds until the next edge
        while (!in_ready && waited < wait_limit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!in_ready) begin
            fail_run("in_ready stayed low, the adder accepted no pair");
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        sent++;
    endtask

    // output side, random stalls once stall_pct is set
    task automatic serve_output();
        forever begin
            @(posedge clk);
            #2;
            out_ready = (stall_pct == 0) || (($urandom % 100) >= stall_pct);
            if (out_valid && out_ready) begin
                results++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (posit_adder_i.chk_i.fail_count != 0) begin
            fail_run("an assertion in the bound checker failed");
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        pd_t x;
        pd_t a;
        pd_t b;
        int  waited;
        void'($urandom(32'hacd));
        in_valid  = 1'b0;
        a_drv     = '0;
        b_drv     = '0;
        out_ready = 1'b0;
        stall_pct = 0;
        sent      = 0;
        results   = 0;
        rst_n     = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        fork
            serve_output();
        join_none

        // pair kinds rotate: x+x, x-x, x+0, NaR
        for (int i = 0; i < n_pairs; i++) begin
            if (i == calm_pairs) begin
                stall_pct = 40;
            end
            x = random_operand();
            if (i % 16 == 0) begin
                x.scale = scale_t'(`MAX_SCALE);
            end
            a = x;
            b = x;
            case (i % 4)
                1: b.sign = ~x.sign;
                2: begin
                    if ($urandom % 2) begin
                        a      = '0;
                        a.zero = 1'b1;
                    end else begin
                        b      = '0;
                        b.zero = 1'b1;
                    end
                end
                3: begin
                    b     = '0;
                    b.nar = 1'b1;
                    if ($urandom % 2) begin
                        b = x;
                        a = '0;
                        a.nar = 1'b1;
                    end
                end
                default: ;
            endcase
            send_pair(a, b);
        end

        waited = 0;
        while (results < sent && waited < wait_limit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (results < sent) begin
            fail_run("timeout while waiting for the remaining results");
        end
        // nothing extra may follow the last result
        repeat (4) @(posedge clk);
        #2;
        if (results == sent && !out_valid && posit_adder_i.chk_i.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            fail_run($sformatf("error at %0t: %0d results for %0d pairs", $time, results, sent));
        end
    end

endmodule

// ==== posit_adder_chk.sv ====
`timescale 1ns/1ps
`include "posit_params.svh"

module posit_adder_chk (
    input logic              clk,
    input logic              rst_n,
    input logic              in_valid,
    input logic              in_ready,
    input logic              a_sign, a_zero, a_nar,
    input posit_pkg::scale_t a_scale,
    input posit_pkg::frac_t  a_frac,
    input logic              b_sign, b_zero, b_nar,
    input posit_pkg::scale_t b_scale,
    input posit_pkg::frac_t  b_frac,
    input logic              out_valid,
    input logic              out_ready,
    input logic              out_sign, out_zero, out_nar,
    input posit_pkg::scale_t out_scale,
    input posit_pkg::frac_t  out_frac,
    input logic              out_guard, out_round, out_sticky
);
    import posit_pkg::*;

    // how much of a result follows from its pair
    localparam logic [1:0] mode_full    = 2'd0;
    localparam logic [1:0] mode_zero    = 2'd1;
    localparam logic [1:0] mode_nar     = 2'd2;
    localparam logic [1:0] mode_not_nar = 2'd3;

    pd_t        a_op;
    pd_t        b_op;
    pd_t        got;
    pd_t        exp_q[$];
    logic [1:0] mode_q[$];
    pd_t        head;
    logic [1:0] head_mode;
    logic       head_valid;
    logic       head_ok;
    int         fail_count = 0;

    assign a_op = {a_sign, a_zero, a_nar, a_scale, a_frac, 3'b000};
    assign b_op = {b_sign, b_zero, b_nar, b_scale, b_frac, 3'b000};
    assign got  = {out_sign, out_zero, out_nar, out_scale, out_frac,
                   out_guard, out_round, out_sticky};

    function automatic logic [1:0] pair_mode(input pd_t a, input pd_t b);
        if (a.nar || b.nar) begin
            return mode_nar;
        end
        if (a.zero && b.zero) begin
            return mode_zero;
        end
        if (a.zero || b.zero) begin
            return mode_full;
        end
        if (a.scale == b.scale && a.frac == b.frac) begin
            return (a.sign == b.sign) ? mode_full : mode_zero;
        end
        return mode_not_nar;
    endfunction

    function automatic pd_t pair_sum(input pd_t a, input pd_t b);
        pd_t r;
        // adding zero gives the other operand back
        r = a.zero ? b : a;
        // x plus x doubles, except at the top of the scale range
        if (!a.zero && !b.zero && a.scale != scale_t'(`MAX_SCALE)) begin
            r.scale = a.scale + scale_t'(1);
        end
        return r;
    endfunction

    function automatic logic result_ok(input pd_t want, input logic [1:0] mode, input pd_t act);
        case (mode)
            mode_nar:     return act.nar;
            mode_zero:    return act.zero && !act.nar;
            mode_not_nar: return !act.nar;
            default:      return act == want;
        endcase
    endfunction

    //////////////////////////////
    // expected results in order
    //////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_q.delete();
            mode_q.delete();
            head       <= '0;
            head_mode  <= mode_full;
            head_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(mode_q.pop_front());
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(pair_sum(a_op, b_op));
                mode_q.push_back(pair_mode(a_op, b_op));
            end
            head_valid <= exp_q.size() > 0;
            if (exp_q.size() > 0) begin
                head      <= exp_q[0];
                head_mode <= mode_q[0];
            end
        end
    end

    assign head_ok = result_ok(head, head_mode, got);

    //////////////////////////////
    // assertions
    //////////////////////////////

    // quiet during reset and on the first edge after it
    assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> (!out_valid && !in_ready))
        else begin
            fail_count++;
            $error("error at %0t: out_valid or in_ready high around reset", $time);
        end

    // three flowing cycles after a transfer the result is there
    assert property (@(posedge clk) disable iff (!rst_n)
        ($past(in_valid && in_ready && out_ready, 3) && $past(out_ready, 2) && $past(out_ready, 1))
        |-> out_valid)
        else begin
            fail_count++;
            $error("error at %0t: out_valid missing three cycles after a transfer", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(got)))
        else begin
            fail_count++;
            $error("error at %0t: output changed while stalled", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out_ready) |-> (head_valid && head_ok))
        else begin
            fail_count++;
            $error("error at %0t: result %h differs from expected %h", $time, got, head);
        end

endmodule

// ==== posit_adder.sv ====
`timescale 1ns/1ps
`include "posit_params.svh"

module posit_adder (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic              a_sign,
    input  logic              a_zero,
    input  logic              a_nar,
    input  posit_pkg::scale_t a_scale,
    input  posit_pkg::frac_t  a_frac,
    input  logic              b_sign,
    input  logic              b_zero,
    input  logic              b_nar,
    input  posit_pkg::scale_t b_scale,
    input  posit_pkg::frac_t  b_frac,
    output logic              out_valid,
    input  logic              out_ready,
    output logic              out_sign,
    output logic              out_zero,
    output logic              out_nar,
    output posit_pkg::scale_t out_scale,
    output posit_pkg::frac_t  out_frac,
    output logic              out_guard,
    output logic              out_round,
    output logic              out_sticky
);
    import posit_pkg::*;

    pd_t                     a_pd;
    pd_t                     b_pd;
    logic [`PIPE_STAGES-1:0] stage_en;
    sig_t                    large_sig;
    sig_t                    small_sig;
    scale_t                  large_scale;
    logic                    large_sign;
    logic                    effective_add;
    logic                    saturate;
    logic                    s2_nar;
    logic                    s2_a_zero;
    logic                    s2_b_zero;

    pd_if op_a ();
    pd_if op_b ();
    pd_if res ();

    // operands have no rounding bits yet
    assign a_pd = '{sign: a_sign, zero: a_zero, nar: a_nar, scale: a_scale, frac: a_frac,
                    guard: 1'b0, round: 1'b0, sticky: 1'b0};
    assign b_pd = '{sign: b_sign, zero: b_zero, nar: b_nar, scale: b_scale, frac: b_frac,
                    guard: 1'b0, round: 1'b0, sticky: 1'b0};

    posit_add_flow flow_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_ready (out_ready),
        .a_in      (a_pd),
        .b_in      (b_pd),
        .op_a      (op_a),
        .op_b      (op_b),
        .stage_en  (stage_en),
        .out_valid (out_valid)
    );

    posit_add_align align_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stage_en      (stage_en[0]),
        .op_a          (op_a),
        .op_b          (op_b),
        .large_sig     (large_sig),
        .small_sig     (small_sig),
        .large_scale   (large_scale),
        .large_sign    (large_sign),
        .effective_add (effective_add),
        .saturate      (saturate),
        .nar           (s2_nar),
        .a_zero        (s2_a_zero),
        .b_zero        (s2_b_zero)
    );

    posit_add_norm norm_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stage_en      (stage_en[2:1]),
        .large_sig     (large_sig),
        .small_sig     (small_sig),
        .large_scale   (large_scale),
        .large_sign    (large_sign),
        .effective_add (effective_add),
        .saturate      (saturate),
        .nar           (s2_nar),
        .a_zero        (s2_a_zero),
        .b_zero        (s2_b_zero),
        .res           (res)
    );

    assign out_sign   = res.sign;
    assign out_zero   = res.zero;
    assign out_nar    = res.nar;
    assign out_scale  = res.scale;
    assign out_frac   = res.frac;
    assign out_guard  = res.guard;
    assign out_round  = res.round;
    assign out_sticky = res.sticky;

endmodule

// ==== posit_add_norm.sv ====
`timescale 1ns/1ps
`include "posit_params.svh"

module posit_add_norm (
    input  logic              clk,
    input  logic              rst_n,
    // bit 0 loads stage 2, bit 1 loads stage 3
    input  logic [1:0]        stage_en,
    input  posit_pkg::sig_t   large_sig,
    input  posit_pkg::sig_t   small_sig,
    input  posit_pkg::scale_t large_scale,
    input  logic              large_sign,
    input  logic              effective_add,
    input  logic              saturate,
    input  logic              nar,
    input  logic              a_zero,
    input  logic              b_zero,
    pd_if.source              res
);
    import posit_pkg::*;

    sig_t              l_sig_r;
    sig_t              s_sig_r;
    scale_t            l_scale_r;
    logic              l_sign_r;
    logic              add_r;
    logic              sat_r;
    logic              nar_r;
    logic              both_zero_r;
    sum_t              sum;
    sum_t              norm_sum;
    logic [`LOD_W-1:0] lod_pos;
    logic [`LOD_W-1:0] norm_shift;
    scale_t            final_scale;
    pd_t               res_next;
    pd_t               res_r;

    //////////////////////////////
    // stage 2 register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            l_sig_r     <= '0;
            s_sig_r     <= '0;
            l_scale_r   <= '0;
            l_sign_r    <= 1'b0;
            add_r       <= 1'b0;
            sat_r       <= 1'b0;
            nar_r       <= 1'b0;
            both_zero_r <= 1'b0;
        end else if (stage_en[0]) begin
            l_sig_r     <= large_sig;
            s_sig_r     <= small_sig;
            l_scale_r   <= large_scale;
            l_sign_r    <= large_sign;
            add_r       <= effective_add;
            sat_r       <= saturate;
            nar_r       <= nar;
            both_zero_r <= a_zero & b_zero;
        end
    end

    // large >= small, so the difference never goes negative
    assign sum = add_r ? sum_t'(l_sig_r) + sum_t'(s_sig_r)
                       : sum_t'(l_sig_r) - sum_t'(s_sig_r);

    // leading one position
    always_comb begin
        lod_pos = '0;
        for (int i = 0; i < `SUM_W; i++) begin
            if (sum[i]) lod_pos = `LOD_W'(i);
        end
    end

    assign norm_shift = `LOD_W'(`SUM_W - 2) - lod_pos;
    // hidden bit ends up just above the top
    assign norm_sum   = sum << (`LOD_W'(`SUM_W) - lod_pos);

    always_comb begin
        if (sum[`SUM_W-1]) begin
            final_scale = sat_r ? l_scale_r : l_scale_r + scale_t'(1);
        end else if (!sum[`SUM_W-2]) begin
            final_scale = l_scale_r - scale_t'(norm_shift);
        end else begin
            final_scale = l_scale_r;
        end
    end

    always_comb begin
        res_next.sign   = l_sign_r;
        res_next.zero   = both_zero_r | (sum == '0);
        res_next.nar    = nar_r;
        res_next.scale  = final_scale;
        res_next.frac   = norm_sum[`SUM_W-1 -: `FRAC_W];
        res_next.guard  = norm_sum[`SUM_W-1-`FRAC_W];
        res_next.round  = norm_sum[`SUM_W-2-`FRAC_W];
        res_next.sticky = |norm_sum[`SUM_W-3-`FRAC_W:0];
    end

    //////////////////////////////
    // stage 3 register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_r <= '0;
        end else if (stage_en[1]) begin
            res_r <= res_next;
        end
    end

    assign res.sign   = res_r.sign;
    assign res.zero   = res_r.zero;
    assign res.nar    = res_r.nar;
    assign res.scale  = res_r.scale;
    assign res.frac   = res_r.frac;
    assign res.guard  = res_r.guard;
    assign res.round  = res_r.round;
    assign res.sticky = res_r.sticky;

endmodule

// ==== posit_add_align.sv ====
`timescale 1ns/1ps
`include "posit_params.svh"

module posit_add_align (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stage_en,
    pd_if.sink                op_a,
    pd_if.sink                op_b,
    output posit_pkg::sig_t   large_sig,
    output posit_pkg::sig_t   small_sig,
    output posit_pkg::scale_t large_scale,
    output logic              large_sign,
    output logic              effective_add,
    output logic              saturate,
    output logic              nar,
    output logic              a_zero,
    output logic              b_zero
);
    import posit_pkg::*;

    pd_t                 a_r;
    pd_t                 b_r;
    logic                a_large;
    pd_t                 l_op;
    pd_t                 s_op;
    sig_t                small_base;
    sig_t                shifted;
    sig_t                lost_mask;
    logic signed [`SCALE_W:0] scale_diff;
    logic [`SCALE_W:0]   shift_amt;

    //////////////////////////////
    // stage 1 register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_r <= '0;
            b_r <= '0;
        end else if (stage_en) begin
            a_r <= {op_a.sign, op_a.zero, op_a.nar, op_a.scale, op_a.frac,
                    op_a.guard, op_a.round, op_a.sticky};
            b_r <= {op_b.sign, op_b.zero, op_b.nar, op_b.scale, op_b.frac,
                    op_b.guard, op_b.round, op_b.sticky};
        end
    end

    // zero is always the smaller one, ties go to a
    always_comb begin
        if (b_r.zero) begin
            a_large = 1'b1;
        end else if (a_r.zero) begin
            a_large = 1'b0;
        end else if (a_r.scale != b_r.scale) begin
            a_large = a_r.scale > b_r.scale;
        end else begin
            a_large = a_r.frac >= b_r.frac;
        end
    end

    assign l_op = a_large ? a_r : b_r;
    assign s_op = a_large ? b_r : a_r;

    // sticky right shift of the small significand
    assign small_base = {~s_op.zero, s_op.frac, {(`SIG_W - `FRAC_W - 1){1'b0}}};
    assign scale_diff = l_op.scale - s_op.scale;
    assign shift_amt  = scale_diff;
    assign shifted    = small_base >> shift_amt;
    assign lost_mask  = ~({`SIG_W{1'b1}} << shift_amt);

    assign small_sig   = {shifted[`SIG_W-1:1], shifted[0] | (|(small_base & lost_mask))};
    assign large_sig   = {~l_op.zero, l_op.frac, {(`SIG_W - `FRAC_W - 1){1'b0}}};
    assign large_scale = l_op.scale;
    assign large_sign  = l_op.sign;

    assign effective_add = a_r.sign == b_r.sign;
    // both at the top of the range, a carry must not grow the scale
    assign saturate = (a_r.scale == `MAX_SCALE) && (b_r.scale == `MAX_SCALE);
    assign nar      = a_r.nar | b_r.nar;
    assign a_zero   = a_r.zero;
    assign b_zero   = b_r.zero;

endmodule

// ==== posit_add_flow.sv ====
`timescale 1ns/1ps
`include "posit_params.svh"

module posit_add_flow (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic                    out_ready,
    input  posit_pkg::pd_t          a_in,
    input  posit_pkg::pd_t          b_in,
    pd_if.source                    op_a,
    pd_if.source                    op_b,
    output logic [`PIPE_STAGES-1:0] stage_en,
    output logic                    out_valid
);
    import posit_pkg::*;

    logic                    process_en;
    logic                    receive_en;
    logic                    skid_full;
    pd_t                     skid_a;
    pd_t                     skid_b;
    pd_t                     sel_a;
    pd_t                     sel_b;
    logic [`PIPE_STAGES-1:0] stage_valid;

    // pipeline moves when the output is taken or empty
    assign process_en = out_ready | ~out_valid;
    assign receive_en = in_valid & in_ready;

    //////////////////////////////
    // input side and skid register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ready  <= 1'b0;
            skid_full <= 1'b0;
        end else begin
            in_ready <= process_en;
            // a pair taken during a stall waits here
            if (receive_en && !process_en) begin
                skid_full <= 1'b1;
            end else if (process_en) begin
                skid_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (receive_en && !process_en) begin
            skid_a <= a_in;
            skid_b <= b_in;
        end
    end

    // held pair goes first
    assign sel_a = skid_full ? skid_a : a_in;
    assign sel_b = skid_full ? skid_b : b_in;

    assign op_a.sign   = sel_a.sign;
    assign op_a.zero   = sel_a.zero;
    assign op_a.nar    = sel_a.nar;
    assign op_a.scale  = sel_a.scale;
    assign op_a.frac   = sel_a.frac;
    assign op_a.guard  = sel_a.guard;
    assign op_a.round  = sel_a.round;
    assign op_a.sticky = sel_a.sticky;

    assign op_b.sign   = sel_b.sign;
    assign op_b.zero   = sel_b.zero;
    assign op_b.nar    = sel_b.nar;
    assign op_b.scale  = sel_b.scale;
    assign op_b.frac   = sel_b.frac;
    assign op_b.guard  = sel_b.guard;
    assign op_b.round  = sel_b.round;
    assign op_b.sticky = sel_b.sticky;

    //////////////////////////////
    // stage valid chain
    //////////////////////////////

    assign stage_en[0] = process_en & (receive_en | skid_full);
    assign stage_en[`PIPE_STAGES-1:1] =
        {(`PIPE_STAGES-1){process_en}} & stage_valid[`PIPE_STAGES-2:0];

    // while flowing each stage takes its predecessor, empty or not
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else if (process_en) begin
            stage_valid[0] <= receive_en | skid_full;
            stage_valid[`PIPE_STAGES-1:1] <= stage_valid[`PIPE_STAGES-2:0];
        end
    end

    assign out_valid = stage_valid[`PIPE_STAGES-1];

endmodule

// ==== pd_if.sv ====
`timescale 1ns/1ps

interface pd_if;
    import posit_pkg::*;

    logic   sign;
    logic   zero;
    logic   nar;
    scale_t scale;
    frac_t  frac;
    logic   guard;
    logic   round;
    logic   sticky;

    modport source (
        output sign, zero, nar, scale, frac, guard, round, sticky
    );

    modport sink (
        input sign, zero, nar, scale, frac, guard, round, sticky
    );

endinterface

// ==== posit_pkg.sv ====
`include "posit_params.svh"

package posit_pkg;

    typedef logic signed [`SCALE_W-1:0] scale_t;
    typedef logic [`FRAC_W-1:0]         frac_t;

    // aligned significand and its sum with one carry bit
    typedef logic [`SIG_W-1:0]          sig_t;
    typedef logic [`SUM_W-1:0]          sum_t;

    // decoded posit
    // guard/round/sticky only carry information on a result
    typedef struct packed {
        logic   sign;
        logic   zero;
        logic   nar;
        scale_t scale;
        frac_t  frac;
        logic   guard;
        logic   round;
        logic   sticky;
    } pd_t;

endpackage

// ==== posit_params.svh ====
`ifndef POSIT_PARAMS_SVH
`define POSIT_PARAMS_SVH

// posit format, 8 bits with es 0
`define POSIT_W     8
`define POSIT_ES    0
`define SCALE_W     5
`define FRAC_W      (`POSIT_W - 3 - `POSIT_ES)

// hidden bit, fraction, guard/round/sticky
`define SIG_W       (`FRAC_W + 4)
`define SUM_W       (`SIG_W + 1)
`define LOD_W       4
`define MAX_SCALE   ((`POSIT_W - 2) << `POSIT_ES)
`define PIPE_STAGES 3

`endif
